//--- Makefile
SRCS := $(shell cat power_seq_top.f)

obj_dir/Vpower_seq_tb: power_seq_top.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f power_seq_top.f \
		--top-module power_seq_tb -o Vpower_seq_tb

.PHONY: run clean

run: obj_dir/Vpower_seq_tb
	./obj_dir/Vpower_seq_tb

clean:
	rm -rf obj_dir

//--- power_seq_top.f
verilog/power_seq_pkg.sv
verilog/pg_input_sync.sv
verilog/rail_stage.sv
verilog/seq_status_collect.sv
verilog/seq_wb_regs.sv
verilog/power_seq_top.sv
verif/tb_clock_gen.sv
verif/power_seq_properties.sv
verif/power_seq_tb.sv

//--- verif/power_seq_golden.txt
// Record count, then one record per line (ff marks no faulty or dropout rail):
// cpub_present faulty_rail dropout_rail status enable_reg pg_reg fail_reg
0006
0001 00ff 00ff 0023 7fff 7fff 0000
0000 00ff 00ff 0003 7fff 7fff 0000
0001 0005 00ff 0036 0000 0000 0020
0001 00ff 0009 002e 0000 0000 0200
0000 000b 00ff 0016 0000 0000 0800
0000 00ff 0002 000e 0000 0000 0004

//--- verif/power_seq_properties.sv
//**********************************************************************
// Concurrent checks on rail ordering, error shutdown and the bus ack
// Bound into the top level so both the collector and the slave are seen
//**********************************************************************
`timescale 1ns/1ps

module power_seq_properties (
	input  logic clk_in,
	input  logic reset,
	input  power_seq_pkg::wb_rsp_t wb_rsp,
	input  power_seq_pkg::rail_vec_t rail_en,
	input  power_seq_pkg::rail_vec_t rail_en_raw,
	input  power_seq_pkg::rail_vec_t pg_sync,
	input  logic err_found,
	input  logic clear_err
);

	power_seq_pkg::rail_vec_t next_pg;

	assign next_pg = {1'b0, pg_sync[power_seq_pkg::RAIL_COUNT-1:1]};

	// Single-cycle ack
	ack_one_cycle: assert property (@(posedge clk_in) disable iff (reset)
		wb_rsp.ack |=> !wb_rsp.ack)
		else $error("Wishbone ack held for two cycles");

	// A rail turns on only behind a good rail below it, or while holding for shutdown
	for (genvar i = 1; i < power_seq_pkg::RAIL_COUNT; i++) begin : g_order
		en_after_pg: assert property (@(posedge clk_in) disable iff (reset)
			$rose(rail_en_raw[i]) |-> ($past(pg_sync[i-1]) || $past(next_pg[i])))
			else $error("Rail %0d enabled without good power below it", i);
	end

	errors_shut_all: assert property (@(posedge clk_in) disable iff (reset)
		(err_found && !clear_err) |-> ##2 (rail_en == '0 && rail_en_raw == '0))
		else $error("Rails still enabled two cycles after an error");

endmodule

bind power_seq_top power_seq_properties u_props (
	.clk_in(clk_in),
	.reset(reset),
	.wb_rsp(wb_rsp),
	.rail_en(rail_en),
	.rail_en_raw(rail_en_raw),
	.pg_sync(pg_sync),
	.err_found(err_found),
	.clear_err(clear_err)
);

//--- verif/power_seq_tb.sv
//**********************************************************************
// Testbench for power_seq_top, driven from verif/power_seq_golden.txt
// Supply model answers each pin enable after 1 to 8 cycles
// Stops at the first mismatch; run from the project root
//**********************************************************************
`timescale 1ns/1ps

module power_seq_tb;

	localparam int WORDS_PER_RECORD = 7;
	localparam int WAIT_LIMIT = power_seq_pkg::RAIL_COUNT *
		(power_seq_pkg::PG_TIMEOUT_CYCLES + power_seq_pkg::SETTLE_CYCLES + 16);

	logic clk_in;
	logic reset;
	logic sysen;
	logic cpub_present_n;
	logic sysgood;
	power_seq_pkg::rail_vec_t rail_pg;
	power_seq_pkg::rail_vec_t rail_en;
	power_seq_pkg::wb_req_t wb_req;
	power_seq_pkg::wb_rsp_t wb_rsp;

	logic [15:0] golden [0:63];
	int record_count;
	int faulty_rail;
	int drop_rail;
	logic drop_active;
	int pg_wait [power_seq_pkg::RAIL_COUNT];

	tb_clock_gen u_clk (
		.clk_in(clk_in),
		.reset(reset)
	);

	power_seq_top dut (
		.clk_in(clk_in),
		.reset(reset),
		.sysen(sysen),
		.cpub_present_n(cpub_present_n),
		.rail_pg(rail_pg),
		.rail_en(rail_en),
		.sysgood(sysgood),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check(input logic [15:0] actual, input logic [15:0] expected,
		input string what);
		if (actual !== expected) begin
			abort_run($sformatf("[ERROR] %0t ns: %s: got %h, expected %h",
				$time, what, actual, expected));
		end
	endtask

	function automatic logic rail_absent(input int j);
		return cpub_present_n && power_seq_pkg::CPUB_RAIL_MASK[j];
	endfunction

	// Supply model and order monitor share one process so pg is read before it moves
	initial begin
		power_seq_pkg::rail_vec_t prev_en;
		logic want;
		void'($urandom(72));
		prev_en = '0;
		rail_pg = '0;
		forever begin
			@(negedge clk_in);
			for (int i = 0; i < power_seq_pkg::RAIL_COUNT; i++) begin
				if (!reset && rail_en[i] && !prev_en[i]) begin
					check(16'(rail_absent(i)), 16'h0, $sformatf("absent rail %0d enabled", i));
					for (int j = 0; j < i; j++) begin
						if (!rail_absent(j)) begin
							check(16'(rail_pg[j]), 16'h1,
								$sformatf("rail %0d on before pg of rail %0d", i, j));
						end
					end
				end
				if (!reset && !sysen && !rail_en[i] && prev_en[i]) begin
					for (int j = i + 1; j < power_seq_pkg::RAIL_COUNT; j++) begin
						check(16'(rail_pg[j]), 16'h0,
							$sformatf("rail %0d off before pg of rail %0d dropped", i, j));
					end
				end
				want = rail_en[i] && (faulty_rail != i) && !(drop_active && drop_rail == i);
				if (want == rail_pg[i]) begin
					pg_wait[i] = 0;
				end else if (pg_wait[i] == 0) begin
					pg_wait[i] = 1 + int'($urandom % 8);
				end else if (pg_wait[i] == 1) begin
					rail_pg[i] <= want;
					pg_wait[i] = 0;
				end else begin
					pg_wait[i] = pg_wait[i] - 1;
				end
			end
			prev_en = rail_en;
		end
	end

	task automatic wb_access(input logic we, input logic [4:0] adr, input logic [7:0] wdat,
		output logic [7:0] rdat);
		int waited;
		waited = 0;
		@(negedge clk_in);
		wb_req.cyc <= 1'b1;
		wb_req.stb <= 1'b1;
		wb_req.we <= we;
		wb_req.adr <= adr;
		wb_req.dat <= wdat;
		do begin
			@(negedge clk_in);
			waited++;
			if (waited > 16) begin
				abort_run("Wishbone slave never acknowledged an access");
			end
		end while (!wb_rsp.ack);
		rdat = wb_rsp.dat;
		// Hold the strobe one more cycle to see ack drop
		@(negedge clk_in);
		check(16'(wb_rsp.ack), 16'h0000, "ack repeated for a held strobe");
		wb_req <= '0;
	endtask

	task automatic read16(input logic [4:0] lo, input logic [4:0] hi, output logic [15:0] v);
		logic [7:0] b0;
		logic [7:0] b1;
		wb_access(1'b0, lo, 8'h00, b0);
		wb_access(1'b0, hi, 8'h00, b1);
		v = {b1, b0};
	endtask

	// 0 sysgood high, 1 sysgood low, 2 any pin on, 3 all pins and pg off
	function automatic logic cond_met(input int what);
		case (what)
			0: return sysgood;
			1: return !sysgood;
			2: return rail_en != '0;
			default: return rail_en == '0 && rail_pg == '0;
		endcase
	endfunction

	task automatic wait_until(input int what, input string desc);
		int waited;
		waited = 0;
		@(negedge clk_in);
		while (!cond_met(what)) begin
			@(negedge clk_in);
			waited++;
			if (waited > WAIT_LIMIT) begin
				abort_run({"Timed out waiting for ", desc});
			end
		end
	endtask

	task automatic check_regs(input logic [7:0] st, input logic [15:0] en,
		input logic [15:0] pg, input logic [15:0] fail, input string tag);
		logic [7:0] rd;
		logic [15:0] word;
		wb_access(1'b0, power_seq_pkg::REG_STATUS, 8'h00, rd);
		check({8'h00, rd}, {8'h00, st}, {tag, " status"});
		read16(power_seq_pkg::REG_EN_LO, power_seq_pkg::REG_EN_HI, word);
		check(word, en, {tag, " enable"});
		read16(power_seq_pkg::REG_PG_LO, power_seq_pkg::REG_PG_HI, word);
		check(word, pg, {tag, " power-good"});
		read16(power_seq_pkg::REG_FAIL_LO, power_seq_pkg::REG_FAIL_HI, word);
		check(word, fail, {tag, " fail detail"});
	endtask

	task automatic run_record(input int r);
		int base;
		logic [7:0] st;
		logic [7:0] rd;
		logic error_case;
		string tag;
		base = 1 + r * WORDS_PER_RECORD;
		st = golden[base+3][7:0];
		tag = $sformatf("record %0d", r);
		error_case = golden[base+1] < power_seq_pkg::RAIL_COUNT ||
			golden[base+2] < power_seq_pkg::RAIL_COUNT;
		cpub_present_n <= ~golden[base][0];
		faulty_rail <= int'(golden[base+1]);
		drop_rail <= int'(golden[base+2]);
		sysen <= 1'b1;
		if (golden[base+1] < power_seq_pkg::RAIL_COUNT) begin
			wait_until(2, "first rail enable");
			wait_until(3, "error shutdown");
		end else begin
			wait_until(0, "sysgood");
			if (golden[base+2] < power_seq_pkg::RAIL_COUNT) begin
				drop_active <= 1'b1;
				wait_until(3, "shutdown after dropout");
			end
		end
		repeat (4) @(negedge clk_in);
		check_regs(st, golden[base+4], golden[base+5], golden[base+6], tag);

		// Heal the supply, clear the latches and power up again
		if (error_case) begin
			faulty_rail <= power_seq_pkg::RAIL_COUNT;
			drop_active <= 1'b0;
			wb_access(1'b1, power_seq_pkg::REG_CLEAR_ERR, 8'h01, rd);
			wait_until(0, "sysgood after clearing the error");
			repeat (4) @(negedge clk_in);
			check_regs((st & 8'h20) | 8'h03, 16'h7fff, 16'h7fff, 16'h0000,
				{tag, " rerun"});
		end

		sysen <= 1'b0;
		wait_until(1, "sysgood to fall");
		wait_until(3, "rails to power down");
		repeat (4) @(negedge clk_in);
		check_regs(st & 8'h20, 16'h0000, 16'h0000, 16'h0000, {tag, " off"});
	endtask

	initial begin
		logic [7:0] rd;
		sysen = 1'b0;
		cpub_present_n = 1'b0;
		wb_req = '0;
		faulty_rail = power_seq_pkg::RAIL_COUNT;
		drop_rail = power_seq_pkg::RAIL_COUNT;
		drop_active = 1'b0;
		$readmemh("verif/power_seq_golden.txt", golden);
		record_count = int'(golden[0]);
		@(negedge clk_in);
		while (reset) begin
			@(negedge clk_in);
		end

		check({1'b0, rail_en}, 16'h0000, "rail_en after reset");
		check(16'(sysgood), 16'h0000, "sysgood after reset");
		wb_access(1'b0, power_seq_pkg::REG_VERSION, 8'h00, rd);
		check({8'h00, rd}, {8'h00, power_seq_pkg::FPGA_VERSION}, "version");
		for (int k = 0; k < 4; k++) begin
			wb_access(1'b0, power_seq_pkg::REG_VENDOR_0 + 5'(k), 8'h00, rd);
			check({8'h00, rd}, {8'h00, power_seq_pkg::VENDOR_ID[k]},
				$sformatf("vendor byte %0d", k));
		end

		for (int r = 0; r < record_count; r++) begin
			run_record(r);
		end
		$display("All tests passed");
		$finish;
	end

	// One worst-case sequence with timeouts per record
	initial begin
		longint limit_ns;
		#1;
		limit_ns = longint'(record_count) * WAIT_LIMIT * 4;
		#(limit_ns);
		abort_run("Watchdog expired before the tests finished");
	end

endmodule

//--- verif/tb_clock_gen.sv
//**********************************************************************
// Testbench clock and reset for the power sequencer
// 4 ns clock period, reset high for the first 5 rising edges
//**********************************************************************
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_in,
	output logic reset
);

	initial begin
		clk_in = 1'b0;
		forever #2 clk_in = ~clk_in;
	end

	// Released on a falling edge, away from the DUT sampling edge
	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clk_in);
		@(negedge clk_in);
		reset <= 1'b0;
	end

endmodule

//--- verilog/pg_input_sync.sv
//********************************************************************
// Two-flop synchronizers for rail power-good and system enable
// cpub_present_n is a static strap and is used without synchronizing
// Absent second-CPU rails report power-good as soon as they are enabled
//********************************************************************
`timescale 1ns/1ps

module pg_input_sync (
	input  logic clk_in,
	input  logic reset,
	input  power_seq_pkg::rail_vec_t rail_pg,
	input  logic sysen,
	input  logic cpub_present_n,
	input  power_seq_pkg::rail_vec_t rail_en_raw,
	output power_seq_pkg::rail_vec_t pg_sync,
	output logic sysen_sync
);

	power_seq_pkg::rail_vec_t pg_meta;
	power_seq_pkg::rail_vec_t pg_stable;
	power_seq_pkg::rail_vec_t pg_forced;
	logic sysen_meta;

	always_ff @(posedge clk_in) begin
		if (reset) begin
			pg_meta <= '0;
			pg_stable <= '0;
			sysen_meta <= 1'b0;
			sysen_sync <= 1'b0;
		end else begin
			pg_meta <= rail_pg;
			pg_stable <= pg_meta;
			sysen_meta <= sysen;
			sysen_sync <= sysen_meta;
		end
	end

	// Missing CPU rails look good while requested so the sequence walks past them
	assign pg_forced = power_seq_pkg::CPUB_RAIL_MASK & rail_en_raw &
		{power_seq_pkg::RAIL_COUNT{cpub_present_n}};

	assign pg_sync = pg_stable | pg_forced;

endmodule

//--- verilog/power_seq_pkg.sv
//********************************************************************
// Shared widths, delays, register map and bus types of the sequencer
// Delays count clk_in cycles and are kept short for simulation
// Rail index 0 is enabled first and shut down last
//********************************************************************
package power_seq_pkg;

	localparam int RAIL_COUNT = 15;

	typedef logic [RAIL_COUNT-1:0] rail_vec_t;

	// Second CPU rails 3, 6, 8, 10, 12 and 14
	localparam rail_vec_t CPUB_RAIL_MASK = 15'h5548;

	localparam int SETTLE_CYCLES = 16;
	localparam int PG_TIMEOUT_CYCLES = 64;
	localparam int CNT_W = $clog2(PG_TIMEOUT_CYCLES + 1);

	typedef logic [CNT_W-1:0] cnt_t;

	localparam int DATA_W = 8;
	localparam int ADDR_W = 5;

	localparam logic [ADDR_W-1:0] REG_VERSION = 5'h00;
	localparam logic [ADDR_W-1:0] REG_CLEAR_ERR = 5'h03;
	localparam logic [ADDR_W-1:0] REG_STATUS = 5'h07;
	localparam logic [ADDR_W-1:0] REG_EN_LO = 5'h08;
	localparam logic [ADDR_W-1:0] REG_EN_HI = 5'h09;
	localparam logic [ADDR_W-1:0] REG_PG_LO = 5'h0A;
	localparam logic [ADDR_W-1:0] REG_PG_HI = 5'h0B;
	localparam logic [ADDR_W-1:0] REG_VENDOR_0 = 5'h0C;
	localparam logic [ADDR_W-1:0] REG_VENDOR_1 = 5'h0D;
	localparam logic [ADDR_W-1:0] REG_VENDOR_2 = 5'h0E;
	localparam logic [ADDR_W-1:0] REG_VENDOR_3 = 5'h0F;
	localparam logic [ADDR_W-1:0] REG_FAIL_LO = 5'h18;
	localparam logic [ADDR_W-1:0] REG_FAIL_HI = 5'h19;

	localparam logic [DATA_W-1:0] FPGA_VERSION = 8'h06;
	// Byte 0 sits at REG_VENDOR_0
	localparam logic [3:0][DATA_W-1:0] VENDOR_ID = {8'h20, 8'h53, 8'h43, 8'h52};

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [ADDR_W-1:0] adr;
		logic [DATA_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [DATA_W-1:0] dat;
	} wb_rsp_t;

	typedef struct packed {
		logic en;
		logic done;
		logic wait_err;
		logic op_err;
	} rail_stat_t;

	typedef struct packed {
		logic [1:0] reserved;
		logic cpub_present;
		logic wait_err;
		logic operation_err;
		logic err_found;
		logic sysen;
		logic sysgood;
	} seq_status_t;

endpackage

//--- verilog/power_seq_top.sv
//********************************************************************
// Power sequencer for 15 rails with a Wishbone status port
// rail_pg and sysen may be asynchronous to clk_in
// cpub_present_n must be stable while the rails are up
//********************************************************************
`timescale 1ns/1ps

module power_seq_top (
	input  logic clk_in,
	input  logic reset,
	input  logic sysen,
	input  logic cpub_present_n,
	input  power_seq_pkg::rail_vec_t rail_pg,
	output power_seq_pkg::rail_vec_t rail_en,
	output logic sysgood,
	input  power_seq_pkg::wb_req_t wb_req,
	output power_seq_pkg::wb_rsp_t wb_rsp
);

	power_seq_pkg::rail_vec_t pg_sync;
	power_seq_pkg::rail_vec_t rail_en_raw;
	power_seq_pkg::rail_vec_t fail_detail;
	power_seq_pkg::rail_vec_t done_vec;
	power_seq_pkg::rail_vec_t prev_done_vec;
	power_seq_pkg::rail_vec_t next_pg_vec;
	power_seq_pkg::rail_stat_t [power_seq_pkg::RAIL_COUNT-1:0] stats;
	power_seq_pkg::seq_status_t status;
	logic sysen_sync;
	logic err_found;
	logic clear_err;

	pg_input_sync u_sync (
		.clk_in(clk_in),
		.reset(reset),
		.rail_pg(rail_pg),
		.sysen(sysen),
		.cpub_present_n(cpub_present_n),
		.rail_en_raw(rail_en_raw),
		.pg_sync(pg_sync),
		.sysen_sync(sysen_sync)
	);

	// First rail starts from the enable, last rail has nobody to wait for
	assign prev_done_vec = {done_vec[power_seq_pkg::RAIL_COUNT-2:0], sysen_sync};
	assign next_pg_vec = {1'b0, pg_sync[power_seq_pkg::RAIL_COUNT-1:1]};

	for (genvar i = 0; i < power_seq_pkg::RAIL_COUNT; i++) begin : g_rail
		assign done_vec[i] = stats[i].done;

		rail_stage u_stage (
			.clk_in(clk_in),
			.reset(reset),
			.sysen_sync(sysen_sync),
			.prev_done(prev_done_vec[i]),
			.pg(pg_sync[i]),
			.next_pg(next_pg_vec[i]),
			.err_found(err_found),
			.stat(stats[i])
		);
	end

	seq_status_collect u_collect (
		.clk_in(clk_in),
		.reset(reset),
		.stats(stats),
		.pg_sync(pg_sync),
		.sysen_sync(sysen_sync),
		.cpub_present_n(cpub_present_n),
		.clear_err(clear_err),
		.err_found(err_found),
		.rail_en_raw(rail_en_raw),
		.rail_en(rail_en),
		.sysgood(sysgood),
		.status(status),
		.fail_detail(fail_detail)
	);

	seq_wb_regs u_regs (
		.clk_in(clk_in),
		.reset(reset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.status(status),
		.rail_en_raw(rail_en_raw),
		.pg_sync(pg_sync),
		.fail_detail(fail_detail),
		.clear_err(clear_err)
	);

endmodule

//--- verilog/rail_stage.sv
//********************************************************************
// Enable, settle delay and fault checks for a single power rail
// pg must already be synchronized to clk_in
// An error is only reported here; the collector latches it
//********************************************************************
`timescale 1ns/1ps

module rail_stage (
	input  logic clk_in,
	input  logic reset,
	input  logic sysen_sync,
	input  logic prev_done,
	input  logic pg,
	input  logic next_pg,
	input  logic err_found,
	output power_seq_pkg::rail_stat_t stat
);

	logic en;
	logic done;
	logic wait_err;
	logic op_err;
	logic en_req;
	logic settle_last;
	logic wait_last;
	power_seq_pkg::cnt_t settle_cnt;
	power_seq_pkg::cnt_t wait_cnt;

	// On in order, held while the next rail is still up, off at once on error
	assign en_req = ((sysen_sync & prev_done) | next_pg) & ~err_found;

	assign settle_last = (settle_cnt == power_seq_pkg::cnt_t'(power_seq_pkg::SETTLE_CYCLES - 1));
	assign wait_last = (wait_cnt == power_seq_pkg::cnt_t'(power_seq_pkg::PG_TIMEOUT_CYCLES - 1));

	always_ff @(posedge clk_in) begin
		if (reset) begin
			en <= 1'b0;
			done <= 1'b0;
			wait_err <= 1'b0;
			op_err <= 1'b0;
			settle_cnt <= '0;
			wait_cnt <= '0;
		end else begin
			en <= en_req;

			// Settle timer restarts whenever pg goes away before done
			if (!en) begin
				done <= 1'b0;
				settle_cnt <= '0;
			end else if (pg && !done) begin
				if (settle_last) begin
					done <= 1'b1;
					settle_cnt <= '0;
				end else begin
					settle_cnt <= settle_cnt + 1'b1;
				end
			end else if (!pg) begin
				settle_cnt <= '0;
			end

			// Watchdog on a rail that never reports good
			if (en && !pg && !done) begin
				if (wait_last) begin
					wait_err <= 1'b1;
				end else begin
					wait_cnt <= wait_cnt + 1'b1;
				end
			end else begin
				wait_cnt <= '0;
				wait_err <= 1'b0;
			end

			// Dropout of a finished rail that is still requested
			op_err <= en & done & ~pg;
		end
	end

	assign stat.en = en;
	assign stat.done = done;
	assign stat.wait_err = wait_err;
	assign stat.op_err = op_err;

endmodule

//--- verilog/seq_status_collect.sv
//********************************************************************
// Gathers the rail stages into error latches, pin enables and sysgood
// Errors stay latched until clear_err, even after the rails are off
// Second-CPU pins are held low while cpub_present_n is high
//********************************************************************
`timescale 1ns/1ps

module seq_status_collect (
	input  logic clk_in,
	input  logic reset,
	input  power_seq_pkg::rail_stat_t [power_seq_pkg::RAIL_COUNT-1:0] stats,
	input  power_seq_pkg::rail_vec_t pg_sync,
	input  logic sysen_sync,
	input  logic cpub_present_n,
	input  logic clear_err,
	output logic err_found,
	output power_seq_pkg::rail_vec_t rail_en_raw,
	output power_seq_pkg::rail_vec_t rail_en,
	output logic sysgood,
	output power_seq_pkg::seq_status_t status,
	output power_seq_pkg::rail_vec_t fail_detail
);

	logic wait_err;
	logic operation_err;
	logic err_found_q;
	logic any_wait_err;
	logic any_op_err;
	power_seq_pkg::rail_vec_t cpub_off;

	always_comb begin
		rail_en_raw = '0;
		any_wait_err = 1'b0;
		any_op_err = 1'b0;
		for (int i = 0; i < power_seq_pkg::RAIL_COUNT; i++) begin
			rail_en_raw[i] = stats[i].en;
			any_wait_err = any_wait_err | stats[i].wait_err;
			any_op_err = any_op_err | stats[i].op_err;
		end
	end

	assign cpub_off = power_seq_pkg::CPUB_RAIL_MASK &
		{power_seq_pkg::RAIL_COUNT{cpub_present_n}};

	always_ff @(posedge clk_in) begin
		if (reset) begin
			wait_err <= 1'b0;
			operation_err <= 1'b0;
			err_found <= 1'b0;
			err_found_q <= 1'b0;
			fail_detail <= '0;
			rail_en <= '0;
			sysgood <= 1'b0;
		end else begin
			err_found_q <= err_found;
			if (clear_err) begin
				wait_err <= 1'b0;
				operation_err <= 1'b0;
				err_found <= 1'b0;
				fail_detail <= '0;
			end else begin
				wait_err <= wait_err | any_wait_err;
				operation_err <= operation_err | any_op_err;
				err_found <= err_found | any_wait_err | any_op_err;
				// Enables have not dropped yet, so the failing rail is the odd one out
				if (err_found && !err_found_q) begin
					fail_detail <= rail_en_raw ^ pg_sync;
				end
			end

			// Pins go low one cycle after an error, ahead of the stage enables
			rail_en <= rail_en_raw & ~cpub_off & {power_seq_pkg::RAIL_COUNT{~err_found}};
			sysgood <= stats[power_seq_pkg::RAIL_COUNT-1].done;
		end
	end

	assign status.reserved = 2'b00;
	assign status.cpub_present = ~cpub_present_n;
	assign status.wait_err = wait_err;
	assign status.operation_err = operation_err;
	assign status.err_found = err_found;
	assign status.sysen = sysen_sync;
	assign status.sysgood = sysgood;

endmodule

//--- verilog/seq_wb_regs.sv
//********************************************************************
// Wishbone classic slave for the status and identity registers
// Every access is acked one cycle after it is sampled, for one cycle
// Only a write to REG_CLEAR_ERR has an effect; other writes are ignored
//********************************************************************
`timescale 1ns/1ps

module seq_wb_regs (
	input  logic clk_in,
	input  logic reset,
	input  power_seq_pkg::wb_req_t wb_req,
	output power_seq_pkg::wb_rsp_t wb_rsp,
	input  power_seq_pkg::seq_status_t status,
	input  power_seq_pkg::rail_vec_t rail_en_raw,
	input  power_seq_pkg::rail_vec_t pg_sync,
	input  power_seq_pkg::rail_vec_t fail_detail,
	output logic clear_err
);

	localparam int PAD_W = 2 * power_seq_pkg::DATA_W - power_seq_pkg::RAIL_COUNT;

	logic ack;
	logic access;
	logic [power_seq_pkg::DATA_W-1:0] rd_data;
	logic [power_seq_pkg::DATA_W-1:0] rd_mux;
	logic [2*power_seq_pkg::DATA_W-1:0] en_word;
	logic [2*power_seq_pkg::DATA_W-1:0] pg_word;
	logic [2*power_seq_pkg::DATA_W-1:0] fail_word;

	// A held strobe during the ack cycle is the same transfer, not a new one
	assign access = wb_req.cyc & wb_req.stb & ~ack;

	// Rail vectors split over a low and a high byte
	assign en_word = {{PAD_W{1'b0}}, rail_en_raw};
	assign pg_word = {{PAD_W{1'b0}}, pg_sync};
	assign fail_word = {{PAD_W{1'b0}}, fail_detail};

	always_comb begin
		case (wb_req.adr)
			power_seq_pkg::REG_VERSION: rd_mux = power_seq_pkg::FPGA_VERSION;
			power_seq_pkg::REG_CLEAR_ERR: rd_mux = '1;
			power_seq_pkg::REG_STATUS: rd_mux = status;
			power_seq_pkg::REG_EN_LO: rd_mux = en_word[power_seq_pkg::DATA_W-1:0];
			power_seq_pkg::REG_EN_HI: rd_mux = en_word[2*power_seq_pkg::DATA_W-1:power_seq_pkg::DATA_W];
			power_seq_pkg::REG_PG_LO: rd_mux = pg_word[power_seq_pkg::DATA_W-1:0];
			power_seq_pkg::REG_PG_HI: rd_mux = pg_word[2*power_seq_pkg::DATA_W-1:power_seq_pkg::DATA_W];
			power_seq_pkg::REG_VENDOR_0: rd_mux = power_seq_pkg::VENDOR_ID[0];
			power_seq_pkg::REG_VENDOR_1: rd_mux = power_seq_pkg::VENDOR_ID[1];
			power_seq_pkg::REG_VENDOR_2: rd_mux = power_seq_pkg::VENDOR_ID[2];
			power_seq_pkg::REG_VENDOR_3: rd_mux = power_seq_pkg::VENDOR_ID[3];
			power_seq_pkg::REG_FAIL_LO: rd_mux = fail_word[power_seq_pkg::DATA_W-1:0];
			power_seq_pkg::REG_FAIL_HI:
				rd_mux = fail_word[2*power_seq_pkg::DATA_W-1:power_seq_pkg::DATA_W];
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (reset) begin
			ack <= 1'b0;
			clear_err <= 1'b0;
		end else begin
			ack <= access;
			// Clear pulse lines up with the ack of the write
			clear_err <= access & wb_req.we & (wb_req.adr == power_seq_pkg::REG_CLEAR_ERR);
		end
	end

	// Read data is sampled with the request and held through ack
	always_ff @(posedge clk_in) begin
		if (access) begin
			rd_data <= rd_mux;
		end
	end

	assign wb_rsp.ack = ack;
	assign wb_rsp.dat = rd_data;

endmodule
